// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= tb_pixel_readout
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "simulation exited with status $$status"; exit 1; fi
	@if grep -q "Errors found" $(LOG); then echo "simulation failed"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== logic/channel_fsm.sv ====
// channel controller: trigger qualification, sample/SAR/burst sequencing and packet build
`timescale 1ns/1ps

module channel_fsm #(
    parameter int unsigned CHANNEL_ID = 0
) (
    input  logic                                 clk,
    input  logic                                 reset_n,
    input  logic                                 hit,              // discriminator fired
    input  logic                                 external_trigger,
    input  logic                                 comp,             // comparator vs dac_code
    input  logic [pixel_pkg::CHIP_ID_BITS-1:0]   chip_id,
    input  logic [pixel_pkg::TIMESTAMP_BITS-1:0] timestamp,
    input  pixel_pkg::channel_cfg_t              cfg,
    input  logic                                 reset_busy,       // csa reset timer running
    input  logic                                 fifo_full,
    output logic [pixel_pkg::ADC_BITS-1:0]       dac_code,         // current SAR trial
    output logic                                 sample,
    output logic                                 reset_start,
    output logic                                 push,
    output pixel_pkg::channel_event_t            push_event
);

    pixel_pkg::channel_state_t state;
    pixel_pkg::channel_state_t next_state;

    logic                          triggered_natural;
    logic                          triggered_external;
    logic                          triggered_channel;
    pixel_pkg::trigger_type_t      trigger_type;
    pixel_pkg::trigger_type_t      trigger_type_latched;
    logic [7:0]                    sample_counter;     // cycles spent in SAMPLE
    logic [7:0]                    burst_counter;      // conversions finished in this burst
    logic [pixel_pkg::ADC_BITS-1:0] sar_mask;          // bit under test, one-hot
    logic [pixel_pkg::ADC_BITS-1:0] adc_word;
    logic [pixel_pkg::PACKET_TIMESTAMP_BITS-1:0] timestamp_latched;
    logic                          final_conversion;
    logic                          code_passes;
    logic                          start_sample;
    logic                          burst_start;

    ////////////////////////////////////////////////////////////
    // triggers

    always_comb begin
        triggered_natural  = hit & ~cfg.channel_mask;
        triggered_external = external_trigger & ~cfg.external_trigger_mask;
        triggered_channel  = triggered_natural | triggered_external;
        trigger_type = triggered_natural ? pixel_pkg::TRIG_NATURAL : pixel_pkg::TRIG_EXTERNAL;
    end

    assign final_conversion = ({1'b0, burst_counter} + 9'd1) >= {1'b0, cfg.adc_burst};
    assign code_passes  = adc_word >= pixel_pkg::ADC_BITS'(cfg.digital_threshold);
    assign start_sample = (next_state == pixel_pkg::SAMPLE) && (state != pixel_pkg::SAMPLE);
    assign burst_start  = (state == pixel_pkg::IDLE) && (next_state == pixel_pkg::SAMPLE);
    assign dac_code     = adc_word | sar_mask;     // settled bits plus the trial bit

    ////////////////////////////////////////////////////////////
    // next state

    always_comb begin
        next_state = state;
        case (state)
            pixel_pkg::IDLE: begin
                if (cfg.enabled && triggered_channel && !reset_busy) begin
                    next_state = pixel_pkg::SAMPLE;
                end
            end
            pixel_pkg::SAMPLE: begin
                if (sample_counter >= cfg.adc_hold_delay) next_state = pixel_pkg::RESET_CSA;
            end
            pixel_pkg::RESET_CSA:       next_state = pixel_pkg::CONVERT;
            pixel_pkg::CONVERT: begin
                if (sar_mask[0]) next_state = pixel_pkg::SAR_DONE;  // lsb trial this cycle
            end
            pixel_pkg::SAR_DONE:        next_state = pixel_pkg::REQUEST_READOUT;
            pixel_pkg::REQUEST_READOUT: begin
                if (!fifo_full) next_state = pixel_pkg::TRANSFER_ADC_CODE;
            end
            pixel_pkg::TRANSFER_ADC_CODE: begin
                next_state = final_conversion ? pixel_pkg::IDLE : pixel_pkg::SAMPLE;
            end
            default:                    next_state = pixel_pkg::IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // control registers and strobes

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state          <= pixel_pkg::IDLE;
            sample_counter <= 8'd0;
            burst_counter  <= 8'd0;
            sar_mask       <= pixel_pkg::SAR_START_MASK;
            adc_word       <= '0;
            sample         <= 1'b1;                     // tracking while idle
            reset_start    <= 1'b0;
            push           <= 1'b0;
        end else begin
            state  <= next_state;
            sample <= (next_state != pixel_pkg::RESET_CSA) && (next_state != pixel_pkg::CONVERT);
            reset_start <= (next_state == pixel_pkg::RESET_CSA) && final_conversion;
            push   <= (next_state == pixel_pkg::TRANSFER_ADC_CODE) && code_passes;
            if (start_sample) begin
                sample_counter <= 8'd0;
                sar_mask       <= pixel_pkg::SAR_START_MASK;
                adc_word       <= '0;
            end else if (state == pixel_pkg::SAMPLE) begin
                sample_counter <= sample_counter + 8'd1;
            end
            if (state == pixel_pkg::CONVERT) begin
                if (comp) adc_word <= adc_word | sar_mask;  // keep the trial bit
                sar_mask <= sar_mask >> 1;
            end
            if (burst_start) begin
                burst_counter <= 8'd0;
            end else if (state == pixel_pkg::TRANSFER_ADC_CODE) begin
                burst_counter <= burst_counter + 8'd1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // packet payload

    always_ff @(posedge clk) begin
        if (burst_start) trigger_type_latched <= trigger_type;
        if (start_sample) timestamp_latched <= timestamp[pixel_pkg::PACKET_TIMESTAMP_BITS-1:0];
        if (next_state == pixel_pkg::TRANSFER_ADC_CODE) begin
            push_event.packet_type  <= pixel_pkg::PACKET_TYPE_DATA;
            push_event.chip_id      <= chip_id;
            push_event.channel_id   <= pixel_pkg::CHANNEL_ID_BITS'(CHANNEL_ID);
            push_event.timestamp    <= timestamp_latched;
            push_event.adc_word     <= adc_word;
            push_event.trigger_type <= trigger_type_latched;
            push_event.downstream   <= 1'b1;
        end
    end

endmodule

// ==== logic/csa_reset_timer.sv ====
// per-channel timer that holds the charge amplifier in reset for the programmed length
`timescale 1ns/1ps

module csa_reset_timer (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       reset_start,         // one-cycle strobe from the channel FSM
    input  logic [7:0] reset_length,
    output logic       csa_reset,
    output logic       busy
);

    logic [7:0] remaining;                  // reset cycles still to go

    ////////////////////////////////////////////////////////////
    // down counter

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            remaining <= 8'd0;
        end else if (reset_start) begin
            remaining <= (reset_length == 8'd0) ? 8'd1 : reset_length; // at least one cycle
        end else if (remaining != 8'd0) begin
            remaining <= remaining - 8'd1;
        end
    end

    assign csa_reset = (remaining != 8'd0);  // rises the cycle after the strobe

    // the strobe cycle counts as busy so no trigger slips in before the count loads
    assign busy = csa_reset | reset_start;

endmodule

// ==== logic/event_arbiter.sv ====
// round-robin arbiter that pops the channels' local FIFOs onto the single event output
`timescale 1ns/1ps

module event_arbiter (
    input  logic                                clk,
    input  logic                                reset_n,
    input  logic [pixel_pkg::NUM_CHANNELS-1:0]  fifo_empty,
    input  pixel_pkg::channel_event_t           head_event [pixel_pkg::NUM_CHANNELS],
    output logic [pixel_pkg::NUM_CHANNELS-1:0]  pop,
    output logic                                event_valid,
    output pixel_pkg::channel_event_t           event_data
);

    typedef logic [$clog2(pixel_pkg::NUM_CHANNELS)-1:0] channel_idx_t;

    channel_idx_t last_grant;               // channel served most recently
    channel_idx_t grant_idx;
    logic         grant_valid;

    ////////////////////////////////////////////////////////////
    // search starts one past the last grant

    always_comb begin
        int candidate;
        grant_valid = 1'b0;
        grant_idx   = last_grant;
        for (int i = 1; i <= pixel_pkg::NUM_CHANNELS; i++) begin
            candidate = (int'(last_grant) + i) % pixel_pkg::NUM_CHANNELS;
            if (!grant_valid && !fifo_empty[candidate]) begin
                grant_valid = 1'b1;
                grant_idx   = channel_idx_t'(candidate);
            end
        end
    end

    always_comb begin
        pop = '0;
        if (grant_valid) pop[grant_idx] = 1'b1;   // at most one pop per cycle
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            last_grant  <= '0;
            event_valid <= 1'b0;
        end else begin
            event_valid <= grant_valid;          // one cycle after the pop
            if (grant_valid) last_grant <= grant_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (grant_valid) event_data <= head_event[grant_idx];
    end

endmodule

// ==== logic/local_fifo.sv ====
// small per-channel register FIFO that queues finished packets for the event arbiter
`timescale 1ns/1ps

module local_fifo (
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      push,
    input  pixel_pkg::channel_event_t push_event,
    input  logic                      pop,
    output pixel_pkg::channel_event_t head_event,
    output logic                      empty,
    output logic                      full
);

    pixel_pkg::channel_event_t mem [pixel_pkg::LOCAL_FIFO_DEPTH];

    logic [pixel_pkg::LOCAL_FIFO_BITS-1:0] wr_ptr;
    logic [pixel_pkg::LOCAL_FIFO_BITS-1:0] rd_ptr;
    logic [pixel_pkg::LOCAL_FIFO_BITS:0]   count;     // occupancy, one extra bit for full
    logic                                  do_push;
    logic                                  do_pop;

    // pointer step with wrap, depth need not be a power of two
    function automatic logic [pixel_pkg::LOCAL_FIFO_BITS-1:0] next_ptr(
        input logic [pixel_pkg::LOCAL_FIFO_BITS-1:0] ptr
    );
        if (ptr == pixel_pkg::LOCAL_FIFO_BITS'(pixel_pkg::LOCAL_FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign do_push = push & ~full;           // writes into a full queue are dropped
    assign do_pop  = pop & ~empty;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop) rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // idle or simultaneous push and pop
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) mem[wr_ptr] <= push_event;
    end

    assign head_event = mem[rd_ptr];
    assign empty      = (count == '0);
    assign full       = (count == (pixel_pkg::LOCAL_FIFO_BITS + 1)'(pixel_pkg::LOCAL_FIFO_DEPTH));

endmodule

// ==== logic/pixel_channel.sv ====
// one readout channel: controller FSM, CSA reset timer and local packet FIFO
`timescale 1ns/1ps

module pixel_channel #(
    parameter int unsigned CHANNEL_ID = 0
) (
    input  logic                                 clk,
    input  logic                                 reset_n,
    input  logic                                 hit,
    input  logic                                 external_trigger,
    input  logic                                 comp,
    input  logic [pixel_pkg::CHIP_ID_BITS-1:0]   chip_id,
    input  logic [pixel_pkg::TIMESTAMP_BITS-1:0] timestamp,
    input  pixel_pkg::channel_cfg_t              cfg,
    input  logic                                 pop,          // from the event arbiter
    output logic [pixel_pkg::ADC_BITS-1:0]       dac_code,
    output logic                                 sample,
    output logic                                 csa_reset,
    output logic                                 fifo_empty,
    output pixel_pkg::channel_event_t            head_event
);

    logic                      reset_start;
    logic                      reset_busy;
    logic                      push;
    logic                      fifo_full;
    pixel_pkg::channel_event_t push_event;

    channel_fsm #(
        .CHANNEL_ID (CHANNEL_ID)
    ) fsm_inst (
        .clk, .reset_n, .hit, .external_trigger, .comp, .chip_id, .timestamp, .cfg,
        .reset_busy, .fifo_full, .dac_code, .sample, .reset_start, .push, .push_event
    );

    csa_reset_timer reset_timer_inst (
        .clk, .reset_n, .reset_start,
        .reset_length (cfg.reset_length),
        .csa_reset,
        .busy         (reset_busy)
    );

    local_fifo fifo_inst (
        .clk, .reset_n, .push, .push_event, .pop, .head_event,
        .empty (fifo_empty),
        .full  (fifo_full)
    );

endmodule

// ==== logic/pixel_pkg.sv ====
// sizes, FSM encoding and packet/config types shared by the pixel readout RTL and testbench
package pixel_pkg;

    localparam int NUM_CHANNELS          = 2;
    localparam int ADC_BITS              = 8;
    localparam int CHANNEL_ID_BITS       = 6;
    localparam int CHIP_ID_BITS          = 8;
    localparam int TIMESTAMP_BITS        = 32;
    localparam int PACKET_TIMESTAMP_BITS = 28;     // timestamp bits kept in a packet
    localparam int LOCAL_FIFO_DEPTH      = 4;
    localparam int LOCAL_FIFO_BITS       = $clog2(LOCAL_FIFO_DEPTH);

    localparam logic [1:0] PACKET_TYPE_DATA = 2'b01;
    localparam logic [ADC_BITS-1:0] SAR_START_MASK = {1'b1, {(ADC_BITS-1){1'b0}}}; // msb trial

    typedef enum logic [1:0] {
        TRIG_NATURAL  = 2'd0,                       // also used when both fire together
        TRIG_EXTERNAL = 2'd1
    } trigger_type_t;

    typedef enum logic [2:0] {
        IDLE              = 3'd0,
        SAMPLE            = 3'd1,
        RESET_CSA         = 3'd2,
        CONVERT           = 3'd3,
        SAR_DONE          = 3'd4,
        REQUEST_READOUT   = 3'd5,
        TRANSFER_ADC_CODE = 3'd6
    } channel_state_t;

    typedef struct packed {
        logic       enabled;
        logic       channel_mask;                  // high blocks natural hits
        logic       external_trigger_mask;         // high blocks external triggers
        logic [7:0] adc_burst;                     // conversions per trigger, 0 acts as 1
        logic [7:0] adc_hold_delay;                // extra sample cycles
        logic [7:0] reset_length;                  // csa reset cycles, 0 acts as 1
        logic [6:0] digital_threshold;             // keep codes at or above this
    } channel_cfg_t;

    // fields run msb first, packet_type sits in the low bits
    typedef struct packed {
        logic                             downstream;     // always 1
        trigger_type_t                    trigger_type;
        logic [ADC_BITS-1:0]              adc_word;
        logic [PACKET_TIMESTAMP_BITS-1:0] timestamp;
        logic [CHANNEL_ID_BITS-1:0]       channel_id;
        logic [CHIP_ID_BITS-1:0]          chip_id;
        logic [1:0]                       packet_type;
    } channel_event_t;

endpackage

// ==== logic/pixel_readout_top.sv ====
// top level of the two-channel pixel readout: channel instances feeding the event arbiter
`timescale 1ns/1ps

module pixel_readout_top (
    input  logic                                 clk,
    input  logic                                 reset_n,
    input  logic [pixel_pkg::NUM_CHANNELS-1:0]   hit,
    input  logic [pixel_pkg::NUM_CHANNELS-1:0]   external_trigger,
    input  logic [pixel_pkg::NUM_CHANNELS-1:0]   comp,
    input  logic [pixel_pkg::CHIP_ID_BITS-1:0]   chip_id,
    input  logic [pixel_pkg::TIMESTAMP_BITS-1:0] timestamp,
    input  pixel_pkg::channel_cfg_t              channel_cfg [pixel_pkg::NUM_CHANNELS],
    output logic [pixel_pkg::ADC_BITS-1:0]       dac_code [pixel_pkg::NUM_CHANNELS],
    output logic [pixel_pkg::NUM_CHANNELS-1:0]   sample,
    output logic [pixel_pkg::NUM_CHANNELS-1:0]   csa_reset,
    output logic                                 event_valid,
    output pixel_pkg::channel_event_t            event_data
);

    logic [pixel_pkg::NUM_CHANNELS-1:0] fifo_empty;
    logic [pixel_pkg::NUM_CHANNELS-1:0] pop;
    pixel_pkg::channel_event_t          head_event [pixel_pkg::NUM_CHANNELS];

    for (genvar g = 0; g < pixel_pkg::NUM_CHANNELS; g++) begin : gen_channel
        pixel_channel #(
            .CHANNEL_ID (g)                  // channel id follows the slot
        ) channel_inst (
            .clk, .reset_n, .chip_id, .timestamp,
            .hit              (hit[g]),
            .external_trigger (external_trigger[g]),
            .comp             (comp[g]),
            .cfg              (channel_cfg[g]),
            .pop              (pop[g]),
            .dac_code         (dac_code[g]),
            .sample           (sample[g]),
            .csa_reset        (csa_reset[g]),
            .fifo_empty       (fifo_empty[g]),
            .head_event       (head_event[g])
        );
    end

    event_arbiter arbiter_inst (
        .clk, .reset_n, .fifo_empty, .head_event, .pop, .event_valid, .event_data
    );

endmodule

// ==== src.f ====
logic/pixel_pkg.sv
logic/csa_reset_timer.sv
logic/local_fifo.sv
logic/channel_fsm.sv
logic/pixel_channel.sv
logic/event_arbiter.sv
logic/pixel_readout_top.sv
testbench/pixel_assertions.sv
testbench/tb_pixel_readout.sv

// ==== testbench/pixel_assertions.sv ====
// concurrent handshake checks on the event arbiter, attached to every instance by bind
`timescale 1ns/1ps

module pixel_assertions (
    input logic                               clk,
    input logic                               reset_n,
    input logic [pixel_pkg::NUM_CHANNELS-1:0] fifo_empty,
    input logic [pixel_pkg::NUM_CHANNELS-1:0] pop,
    input logic                               event_valid
);

    ////////////////////////////////////////////////////////////
    // pop strobes

    pop_onehot: assert property (@(posedge clk) disable iff (!reset_n) $onehot0(pop))
        else $error("more than one channel popped in one cycle");

    pop_not_empty: assert property (@(posedge clk) disable iff (!reset_n)
        (pop & fifo_empty) == '0)
        else $error("pop issued to an empty local FIFO");

    ////////////////////////////////////////////////////////////
    // event output

    valid_after_pop: assert property (@(posedge clk) disable iff (!reset_n)
        (|pop) |=> event_valid)
        else $error("event_valid missing one cycle after a pop");

endmodule

bind event_arbiter pixel_assertions arbiter_checks (
    .clk, .reset_n, .fifo_empty, .pop, .event_valid
);

// ==== testbench/tb_pixel_readout.sv ====
// drives the pixel readout top from a stimulus table and checks its packets and strobes
`timescale 1ns/1ps

module tb_pixel_readout;

    localparam int NROWS   = 8;
    localparam int TIMEOUT = 400;                      // cycles allowed per wait

    logic                                 clk;
    logic                                 reset_n;
    logic [pixel_pkg::NUM_CHANNELS-1:0]   hit;
    logic [pixel_pkg::NUM_CHANNELS-1:0]   external_trigger;
    logic [pixel_pkg::NUM_CHANNELS-1:0]   comp = '0;
    logic [pixel_pkg::CHIP_ID_BITS-1:0]   chip_id;
    logic [pixel_pkg::TIMESTAMP_BITS-1:0] timestamp = '0;  // free-running counter
    pixel_pkg::channel_cfg_t              channel_cfg [pixel_pkg::NUM_CHANNELS];
    logic [pixel_pkg::ADC_BITS-1:0]       dac_code [pixel_pkg::NUM_CHANNELS];
    logic [pixel_pkg::NUM_CHANNELS-1:0]   sample;
    logic [pixel_pkg::NUM_CHANNELS-1:0]   csa_reset;
    logic                                 event_valid;
    pixel_pkg::channel_event_t            event_data;

    ////////////////////////////////////////////////////////////
    // stimulus table

    logic [1:0]               hit_tab [NROWS];
    logic [1:0]               ext_tab [NROWS];
    pixel_pkg::channel_cfg_t  cfg_tab [NROWS][2];
    int                       ana_tab [NROWS][2];     // analog value, -1 draws a random one
    int                       cnt_tab [NROWS][2];     // packets expected per channel
    pixel_pkg::trigger_type_t typ_tab [NROWS];
    bit                       pulse_tab [NROWS][2];   // csa reset pulse expected

    pixel_pkg::channel_event_t ev_q [$];
    int ev_ts_q [$];                                  // counter value when event_valid seen
    int run_len [2]  = '{0, 0};
    int pulses [2]   = '{0, 0};
    int last_len [2] = '{0, 0};
    int low_cycles [2] = '{0, 0};                     // cycles with sample low
    int first_low [2]  = '{-1, -1};                   // counter value when sample first fell
    int analog [2]   = '{0, 0};
    int errors       = 0;
    int hit_ts       = 0;
    bit timed_out    = 0;

    pixel_readout_top dut0 (
        .clk, .reset_n, .hit, .external_trigger, .comp, .chip_id, .timestamp, .channel_cfg,
        .dac_code, .sample, .csa_reset, .event_valid, .event_data
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // counter and comparator model, both on the falling edge
    always @(negedge clk) begin
        timestamp <= timestamp + 1;
        for (int c = 0; c < 2; c++) comp[c] <= (analog[c] >= int'(dac_code[c]));
    end

    // event capture, sample and csa reset pulse measurement
    always @(negedge clk) begin
        if (event_valid) begin
            ev_q.push_back(event_data);
            ev_ts_q.push_back(int'(timestamp));
        end
        for (int c = 0; c < 2; c++) begin
            if (csa_reset[c]) begin
                run_len[c]++;
            end else if (run_len[c] != 0) begin
                pulses[c]++;
                last_len[c] = run_len[c];
                run_len[c]  = 0;
            end
            if (!sample[c]) begin
                low_cycles[c]++;
                if (first_low[c] < 0) first_low[c] = int'(timestamp);
            end
        end
    end

    function automatic pixel_pkg::channel_cfg_t make_cfg(input bit en, input bit cm,
        input bit em, input int burst, input int hold, input int rlen, input int thr);
        pixel_pkg::channel_cfg_t cfg;
        cfg.enabled               = en;
        cfg.channel_mask          = cm;
        cfg.external_trigger_mask = em;
        cfg.adc_burst             = 8'(burst);
        cfg.adc_hold_delay        = 8'(hold);
        cfg.reset_length          = 8'(rlen);
        cfg.digital_threshold     = 7'(thr);
        return cfg;
    endfunction

    task automatic set_row(input int r, input logic [1:0] h, input logic [1:0] e,
        input pixel_pkg::channel_cfg_t c0, input pixel_pkg::channel_cfg_t c1,
        input int a0, input int a1, input int n0, input int n1,
        input pixel_pkg::trigger_type_t typ, input bit p0, input bit p1);
        hit_tab[r] = h;
        ext_tab[r] = e;
        cfg_tab[r] = '{c0, c1};
        ana_tab[r] = '{a0, a1};
        cnt_tab[r] = '{n0, n1};
        typ_tab[r] = typ;
        pulse_tab[r] = '{p0, p1};
    endtask

    task automatic report_mismatch(input string msg);
        errors++;
        $display("mismatch at %0t: %s", $time, msg);
    endtask

    function automatic bit all_idle();
        return (dut0.gen_channel[0].channel_inst.fsm_inst.state == pixel_pkg::IDLE)
            && (dut0.gen_channel[1].channel_inst.fsm_inst.state == pixel_pkg::IDLE)
            && (&dut0.fifo_empty) && (csa_reset == '0) && !event_valid;
    endfunction

    task automatic check_row(input int r);
        int seen [2];
        int last_ts [2];
        int ch;
        int ts;
        int exp_len;
        int conv;
        int exp_low;
        int exp_fall;
        pixel_pkg::channel_event_t ev;
        seen    = '{0, 0};
        last_ts = '{-1, -1};
        foreach (ev_q[i]) begin
            ev = ev_q[i];
            ch = int'(ev.channel_id);
            ts = int'(ev.timestamp);
            if (ch > 1) begin
                report_mismatch($sformatf("row %0d unknown channel id %0d", r, ch));
            end else begin
                seen[ch]++;
                if (int'(ev.adc_word) != analog[ch])
                    report_mismatch($sformatf("row %0d ch %0d code %0d expected %0d",
                        r, ch, ev.adc_word, analog[ch]));
                if (ev.chip_id != chip_id)
                    report_mismatch($sformatf("row %0d chip id %0h", r, ev.chip_id));
                if (ev.packet_type != pixel_pkg::PACKET_TYPE_DATA || ev.downstream != 1'b1)
                    report_mismatch($sformatf("row %0d bad packet type or downstream", r));
                if (ev.trigger_type != typ_tab[r])
                    report_mismatch($sformatf("row %0d ch %0d trigger type %0d",
                        r, ch, ev.trigger_type));
                if (ts < hit_ts || ts > ev_ts_q[i] || ts <= last_ts[ch])
                    report_mismatch($sformatf("row %0d ch %0d timestamp %0d out of order",
                        r, ch, ts));
                last_ts[ch] = ts;
            end
        end
        for (int c = 0; c < 2; c++) begin
            exp_len = (cfg_tab[r][c].reset_length == 0) ? 1 : int'(cfg_tab[r][c].reset_length);
            if (seen[c] != cnt_tab[r][c]) begin
                errors++;
                $display("row %0d: channel %0d sent %0d packets, %0d were expected",
                    r, c, seen[c], cnt_tab[r][c]);
            end
            if (pulses[c] != int'(pulse_tab[r][c]))
                report_mismatch($sformatf("row %0d ch %0d saw %0d csa reset pulses",
                    r, c, pulses[c]));
            else if (pulse_tab[r][c] && last_len[c] != exp_len)
                report_mismatch($sformatf("row %0d ch %0d csa reset lasted %0d, expected %0d",
                    r, c, last_len[c], exp_len));
            // a triggered channel ends its burst with a csa reset pulse
            conv = 0;
            if (pulse_tab[r][c])
                conv = (cfg_tab[r][c].adc_burst == 0) ? 1 : int'(cfg_tab[r][c].adc_burst);
            exp_low  = conv * (1 + pixel_pkg::ADC_BITS);     // RESET_CSA plus CONVERT
            exp_fall = hit_ts + int'(cfg_tab[r][c].adc_hold_delay) + 2;  // edge plus hold+1
            if (low_cycles[c] != exp_low)
                report_mismatch($sformatf("row %0d ch %0d sample low %0d cycles, expected %0d",
                    r, c, low_cycles[c], exp_low));
            if (conv != 0 && first_low[c] != exp_fall)
                report_mismatch($sformatf("row %0d ch %0d sample fell at %0d, expected %0d",
                    r, c, first_low[c], exp_fall));
        end
    endtask

    task automatic run_row(input int r);
        int total;
        int waited;
        @(posedge clk);
        ev_q.delete();
        ev_ts_q.delete();
        for (int c = 0; c < 2; c++) begin
            pulses[c]     = 0;
            low_cycles[c] = 0;
            first_low[c]  = -1;
            analog[c] = (ana_tab[r][c] < 0) ? int'($urandom % 256) : ana_tab[r][c];
        end
        @(negedge clk);
        channel_cfg = cfg_tab[r];
        @(negedge clk);
        hit_ts = int'(timestamp);
        hit = hit_tab[r];
        external_trigger = ext_tab[r];
        @(negedge clk);
        hit = '0;
        external_trigger = '0;
        total  = cnt_tab[r][0] + cnt_tab[r][1];
        waited = 0;
        while (ev_q.size() < total && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (ev_q.size() < total) begin
            errors++;
            timed_out = 1;
            $display("row %0d: timed out waiting for event_valid, packets are missing", r);
        end
        waited = 0;
        while (!timed_out && !all_idle() && waited < TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= TIMEOUT) begin
            errors++;
            timed_out = 1;
            $display("row %0d: timed out waiting for the channels to return to idle", r);
        end
        repeat (3) @(negedge clk);
        @(posedge clk);
        if (!timed_out) check_row(r);
    endtask

    initial begin
        pixel_pkg::channel_cfg_t dc;
        void'($urandom(43));
        reset_n = 1'b0;
        hit = '0;
        external_trigger = '0;
        chip_id = 8'h5a;
        channel_cfg = '{'0, '0};
        dc = make_cfg(1, 0, 0, 1, 2, 3, 0);
        set_row(0, 2'b01, 2'b00, dc, dc, 100, 50, 1, 0, pixel_pkg::TRIG_NATURAL, 1, 0);
        set_row(1, 2'b00, 2'b11, dc, make_cfg(1, 0, 1, 1, 2, 3, 0), 77, 200, 1, 0,
            pixel_pkg::TRIG_EXTERNAL, 1, 0);
        set_row(2, 2'b10, 2'b00, dc, make_cfg(1, 0, 0, 3, 1, 5, 0), 10, 150, 0, 3,
            pixel_pkg::TRIG_NATURAL, 0, 1);
        set_row(3, 2'b01, 2'b00, make_cfg(1, 0, 0, 1, 0, 4, 100), dc, 40, 0, 0, 0,
            pixel_pkg::TRIG_NATURAL, 1, 0);
        set_row(4, 2'b11, 2'b00, make_cfg(1, 1, 0, 1, 2, 3, 0), make_cfg(0, 0, 0, 1, 2, 3, 0),
            90, 90, 0, 0, pixel_pkg::TRIG_NATURAL, 0, 0);
        set_row(5, 2'b11, 2'b00, dc, dc, -1, -1, 1, 1, pixel_pkg::TRIG_NATURAL, 1, 1);
        set_row(6, 2'b11, 2'b11, make_cfg(1, 0, 0, 2, 0, 2, 0), make_cfg(1, 0, 0, 2, 0, 2, 0),
            -1, -1, 2, 2, pixel_pkg::TRIG_NATURAL, 1, 1);
        set_row(7, 2'b01, 2'b00, make_cfg(1, 0, 0, 1, 0, 0, 0), dc, 255, 0, 1, 0,
            pixel_pkg::TRIG_NATURAL, 1, 0);
        repeat (2) @(negedge clk);
        reset_n = 1'b1;                                // two rising edges seen in reset
        for (int r = 0; r < NROWS && !timed_out; r++) run_row(r);
        $display("error count: %0d", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
